// ==== Makefile ====
TOP := decode_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f mips_decode.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf obj_dir

// ==== bench/decode_tb.sv ====
`timescale 1ns/1ps
`include "decode_cfg.svh"

module decode_tb;
	import decode_pkg::*;

	localparam int N_PLANNED   = 256;	// upper bound on issued instructions
	localparam int WATCHDOG_NS = 20 * N_PLANNED + 500;

	localparam logic [5:0] FN_LIST [8] = '{FN_ADD, FN_SUB, FN_AND, FN_OR,
		FN_SLT, FN_SLL, FN_SRL, FN_JR};
	localparam logic [5:0] OP_LIST [8] = '{OP_LW, OP_SW, OP_BEQ, OP_BNE,
		OP_ADDI, OP_ANDI, OP_ORI, OP_LUI};
	localparam wb_write_t NO_WRITE = '0;

	logic                      clk;
	logic                      reset;
	logic [`DECODE_DATA_W-1:0] pc_next;
	instr_u                    instr;
	wb_write_t                 wb;
	logic                      flush;
	id_ex_t                    id_ex;
	logic                      stall;
	logic                      jump_taken;
	logic [`DECODE_DATA_W-1:0] jump_target;

	logic [`DECODE_DATA_W-1:0] ref_regs [`DECODE_REG_COUNT];
	id_ex_t                    exp_q;	// what id_ex holds right now
	int                        errors;
	int                        prop_errors;
	int                        checks;
	int                        issued;

	decode_top dut0 (
		.clk         (clk),
		.reset       (reset),
		.pc_next     (pc_next),
		.instr       (instr),
		.wb          (wb),
		.flush       (flush),
		.id_ex       (id_ex),
		.stall       (stall),
		.jump_taken  (jump_taken),
		.jump_target (jump_target)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: the test sequence did not finish in %0d ns", WATCHDOG_NS);
		$display("** FAIL **");
		$finish;
	end

	//////////////////////////////////////////////////
	// properties
	//////////////////////////////////////////////////
	flush_quiet: assert property (@(posedge clk) disable iff (reset)
		flush |-> (!stall && !jump_taken))
	else
	begin
		prop_errors++;
		$display("flush did not hold stall and jump_taken low at %0t", $time);
	end

	flush_clears: assert property (@(posedge clk) disable iff (reset)
		$past(flush) |-> (id_ex == '0))
	else
	begin
		prop_errors++;
		$display("id_ex was not cleared after a flush at %0t", $time);
	end

	//////////////////////////////////////////////////
	// instruction words and reference model
	//////////////////////////////////////////////////
	function automatic instr_u rtype_instr(input logic [5:0] fn,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd,
		input logic [4:0] sh);
		instr_u w;
		w.r.opcode = OP_RTYPE;
		w.r.rs     = rs;
		w.r.rt     = rt;
		w.r.rd     = rd;
		w.r.shamt  = sh;
		w.r.funct  = fn;
		return w;
	endfunction

	function automatic instr_u itype_instr(input logic [5:0] op,
		input logic [4:0] rs, input logic [4:0] rt, input logic [15:0] imm);
		instr_u w;
		w.i.opcode = op;
		w.i.rs     = rs;
		w.i.rt     = rt;
		w.i.imm    = imm;
		return w;
	endfunction

	function automatic instr_u jtype_instr(input logic [5:0] op, input logic [25:0] idx);
		instr_u w;
		w.j.opcode = op;
		w.j.index  = idx;
		return w;
	endfunction

	// control table, row by row
	function automatic ctrl_t ref_control(input logic [5:0] op, input logic [5:0] fn);
		ctrl_t c;
		c = '0;
		if (op == OP_RTYPE)
		begin
			if (fn == FN_JR)
				c.ex.jump_reg = 1'b1;
			else
			begin
				c.ex.reg_dst_rd = 1'b1;
				c.wb.reg_write  = 1'b1;
				case (fn)
					FN_ADD:  c.ex.alu_op = ALU_ADD;
					FN_SUB:  c.ex.alu_op = ALU_SUB;
					FN_AND:  c.ex.alu_op = ALU_AND;
					FN_OR:   c.ex.alu_op = ALU_OR;
					FN_SLT:  c.ex.alu_op = ALU_SLT;
					FN_SLL:  c.ex.alu_op = ALU_SLL;
					default: c.ex.alu_op = ALU_SRL;
				endcase
			end
		end
		else if (op == OP_LW || op == OP_SW)
		begin
			c.ex.alu_op       = ALU_ADD;
			c.ex.alu_src_imm  = 1'b1;
			c.mem.mem_read    = (op == OP_LW);
			c.mem.mem_write   = (op == OP_SW);
			c.wb.reg_write    = (op == OP_LW);
			c.wb.mem_to_reg   = (op == OP_LW);
		end
		else if (op == OP_BEQ || op == OP_BNE)
		begin
			c.ex.alu_op    = ALU_SUB;
			c.ex.branch_eq = (op == OP_BEQ);
			c.ex.branch_ne = (op == OP_BNE);
		end
		else if (op == OP_ADDI || op == OP_ANDI || op == OP_ORI || op == OP_LUI)
		begin
			c.ex.alu_src_imm = 1'b1;
			c.wb.reg_write   = 1'b1;
			if (op == OP_ADDI)
				c.ex.alu_op = ALU_ADD;
			else if (op == OP_ANDI)
				c.ex.alu_op = ALU_AND;
			else if (op == OP_ORI)
				c.ex.alu_op = ALU_OR;
			else
				c.ex.alu_op = ALU_LUI;
		end
		else if (op == OP_J || op == OP_JAL)
		begin
			c.ex.jump      = 1'b1;
			c.ex.link      = (op == OP_JAL);
			c.wb.reg_write = (op == OP_JAL);
		end
		return c;
	endfunction

	// value a read port must show, with the write landing this cycle
	function automatic logic [31:0] expected_read(input logic [4:0] addr,
		input wb_write_t wr);
		if (addr == 5'd0)
			return '0;
		if (wr.we && (wr.addr == addr))
			return wr.data;
		return ref_regs[addr];
	endfunction

	function automatic wb_write_t random_write();
		wb_write_t w;
		w.we   = 1'b1;
		w.addr = 5'($urandom);
		w.data = $urandom;
		return w;
	endfunction

	function automatic logic [31:0] word_aligned_pc();
		return $urandom & 32'hffff_fffc;
	endfunction

	function automatic instr_u mixed_instr();
		int unsigned pick;
		pick = $urandom_range(18, 0);
		if (pick < 8)
			return rtype_instr(FN_LIST[3'(pick)], 5'($urandom), 5'($urandom),
				5'($urandom), 5'($urandom));
		else if (pick < 16)
			return itype_instr(OP_LIST[3'(pick - 8)], 5'($urandom), 5'($urandom),
				16'($urandom));
		else if (pick == 16)
			return jtype_instr(OP_J, 26'($urandom));
		else if (pick == 17)
			return jtype_instr(OP_JAL, 26'($urandom));
		else
			return itype_instr(6'h3f, 5'($urandom), 5'($urandom), 16'($urandom));
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		value_ok: assert (got === exp)
		else
		begin
			errors++;
			$display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	//////////////////////////////////////////////////
	// one instruction through ID, checked both sides of the edge
	//////////////////////////////////////////////////
	task automatic present(input instr_u word, input logic [31:0] pc,
		input wb_write_t wr, input logic fl);
		ctrl_t       exp_ctrl;
		id_ex_t      exp_next;
		logic [31:0] exp_r1;
		logic [31:0] exp_r2;
		logic [31:0] exp_target;
		logic        hazard;
		logic        exp_taken;
		instr   = word;
		pc_next = pc;
		wb      = wr;
		flush   = fl;
		exp_ctrl = ref_control(word.r.opcode, word.r.funct);
		exp_r1   = expected_read(word.r.rs, wr);
		exp_r2   = expected_read(word.r.rt, wr);
		hazard   = exp_q.ctrl.mem.mem_read && (exp_q.rt != 5'd0)
			&& ((exp_q.rt == word.r.rs) || (exp_q.rt == word.r.rt));
		exp_taken = !fl && (exp_ctrl.ex.jump || exp_ctrl.ex.jump_reg);
		if (fl)
			exp_target = '0;
		else if (exp_ctrl.ex.jump_reg)
			exp_target = exp_r1;	// jr goes to rs
		else
			exp_target = {pc[31:28], word.j.index, 2'b00};

		@(negedge clk);
		check_value("stall", 32'(stall), 32'(hazard && !fl));
		check_value("jump_taken", 32'(jump_taken), 32'(exp_taken));
		if (exp_taken || fl)
			check_value("jump_target", jump_target, exp_target);

		exp_next = '0;
		if (!fl)
		begin
			exp_next.pc_next  = pc;
			exp_next.reg1     = exp_r1;
			exp_next.reg2     = exp_r2;
			exp_next.sign_ext = {{16{word.i.imm[15]}}, word.i.imm};
			exp_next.rs       = word.r.rs;
			exp_next.rt       = word.r.rt;
			exp_next.rd       = word.r.rd;
			exp_next.shamt    = word.r.shamt;
			if (!hazard)
				exp_next.ctrl = exp_ctrl;	// bubble keeps it zero
		end

		@(posedge clk);
		#1;
		if (wr.we && (wr.addr != 5'd0))
			ref_regs[wr.addr] = wr.data;
		exp_q = exp_next;
		check_value("id_ex.pc_next", id_ex.pc_next, exp_q.pc_next);
		check_value("id_ex.reg1", id_ex.reg1, exp_q.reg1);
		check_value("id_ex.reg2", id_ex.reg2, exp_q.reg2);
		check_value("id_ex.sign_ext", id_ex.sign_ext, exp_q.sign_ext);
		check_value("id_ex.rs", 32'(id_ex.rs), 32'(exp_q.rs));
		check_value("id_ex.rt", 32'(id_ex.rt), 32'(exp_q.rt));
		check_value("id_ex.rd", 32'(id_ex.rd), 32'(exp_q.rd));
		check_value("id_ex.shamt", 32'(id_ex.shamt), 32'(exp_q.shamt));
		check_value("id_ex.ctrl", 32'(id_ex.ctrl), 32'(exp_q.ctrl));
		issued++;
	endtask

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////
	initial
	begin
		wb_write_t  wr;
		logic [4:0] a;
		int         total;
		void'($urandom(32'h52ce));
		reset       = 1'b1;
		pc_next     = '0;
		instr       = '0;
		wb          = NO_WRITE;
		flush       = 1'b0;
		errors      = 0;
		prop_errors = 0;
		checks      = 0;
		issued      = 0;
		ref_regs    = '{default: '0};
		exp_q       = '0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		check_value("stall", 32'(stall), 32'd0);
		check_value("id_ex cleared", 32'(id_ex == '0), 32'd1);

		// writes, every third read back in the same cycle
		for (int k = 0; k < 40; k++)
		begin
			wr = random_write();
			a  = (k % 3 == 0) ? wr.addr : 5'($urandom);
			present(rtype_instr(FN_ADD, a, 5'($urandom), 5'($urandom), 5'd0),
				word_aligned_pc(), wr, 1'b0);
		end
		wr.we   = 1'b1;
		wr.addr = 5'd0;
		wr.data = 32'hdead_beef;
		present(rtype_instr(FN_OR, 5'd0, 5'd0, 5'd1, 5'd0), word_aligned_pc(), wr, 1'b0);
		present(rtype_instr(FN_OR, 5'd0, 5'd0, 5'd1, 5'd0), word_aligned_pc(), NO_WRITE,
			1'b0);
		for (int k = 1; k < 32; k += 2)
			present(rtype_instr(FN_AND, 5'(k), 5'(k + 1), 5'd2, 5'd0), word_aligned_pc(),
				NO_WRITE, 1'b0);

		// R-type functions
		for (int k = 0; k < 16; k++)
			present(rtype_instr(FN_LIST[3'(k % 8)], 5'($urandom), 5'($urandom),
				5'($urandom), 5'($urandom)), word_aligned_pc(), NO_WRITE, 1'b0);

		// I-type, positive then negative immediate
		for (int k = 0; k < 8; k++)
		begin
			present(itype_instr(OP_LIST[3'(k)], 5'($urandom), 5'($urandom),
				16'($urandom) & 16'h7fff), word_aligned_pc(), NO_WRITE, 1'b0);
			present(itype_instr(OP_LIST[3'(k)], 5'($urandom), 5'($urandom),
				16'($urandom) | 16'h8000), word_aligned_pc(), NO_WRITE, 1'b0);
		end
		present(itype_instr(6'h3f, 5'd3, 5'd4, 16'h1234), word_aligned_pc(), NO_WRITE, 1'b0);
		present(itype_instr(6'h01, 5'd5, 5'd6, 16'hfedc), word_aligned_pc(), NO_WRITE, 1'b0);

		// load-use pairs
		present(itype_instr(OP_LW, 5'd2, 5'd5, 16'h0010), word_aligned_pc(), NO_WRITE, 1'b0);
		present(rtype_instr(FN_ADD, 5'd5, 5'd6, 5'd7, 5'd0), word_aligned_pc(), NO_WRITE,
			1'b0);	// rs hit
		present(itype_instr(OP_LW, 5'd2, 5'd9, 16'h0020), word_aligned_pc(), NO_WRITE, 1'b0);
		present(itype_instr(OP_SW, 5'd3, 5'd9, 16'h0004), word_aligned_pc(), NO_WRITE,
			1'b0);	// rt hit
		present(itype_instr(OP_LW, 5'd2, 5'd0, 16'h0030), word_aligned_pc(), NO_WRITE, 1'b0);
		present(rtype_instr(FN_ADD, 5'd0, 5'd0, 5'd4, 5'd0), word_aligned_pc(), NO_WRITE,
			1'b0);
		present(itype_instr(OP_LW, 5'd2, 5'd10, 16'h0040), word_aligned_pc(), NO_WRITE, 1'b0);
		present(rtype_instr(FN_ADD, 5'd11, 5'd12, 5'd13, 5'd0), word_aligned_pc(), NO_WRITE,
			1'b0);

		// flush, one with a pending hazard
		present(itype_instr(OP_LW, 5'd1, 5'd3, 16'h0000), word_aligned_pc(), NO_WRITE, 1'b0);
		present(rtype_instr(FN_ADD, 5'd3, 5'd4, 5'd5, 5'd0), word_aligned_pc(), NO_WRITE,
			1'b1);
		present(jtype_instr(OP_JAL, 26'($urandom)), word_aligned_pc(), random_write(), 1'b1);
		present(rtype_instr(FN_JR, 5'd8, 5'd0, 5'd0, 5'd0), word_aligned_pc(), NO_WRITE, 1'b1);
		present(rtype_instr(FN_SUB, 5'd1, 5'd2, 5'd3, 5'd0), word_aligned_pc(), NO_WRITE, 1'b0);

		// jumps
		for (int k = 0; k < 2; k++)
		begin
			present(jtype_instr(OP_J, 26'($urandom)), word_aligned_pc(), NO_WRITE, 1'b0);
			present(jtype_instr(OP_JAL, 26'($urandom)), word_aligned_pc(), NO_WRITE, 1'b0);
		end
		a = 5'($urandom_range(31, 1));
		present(rtype_instr(FN_JR, a, 5'd0, 5'd0, 5'd0), word_aligned_pc(), NO_WRITE, 1'b0);
		wr      = random_write();
		wr.addr = a;	// target arrives through write-through
		present(rtype_instr(FN_JR, a, 5'd0, 5'd0, 5'd0), word_aligned_pc(), wr, 1'b0);

		// mixed traffic
		for (int k = 0; k < 100; k++)
		begin
			wr = ($urandom_range(1, 0) == 1) ? random_write() : NO_WRITE;
			present(mixed_instr(), word_aligned_pc(), wr, ($urandom_range(15, 0) == 0));
		end

		wb    = NO_WRITE;
		instr = '0;
		flush = 1'b0;
		repeat (2) @(posedge clk);
		total = errors + prop_errors;
		$display("%0d instructions, %0d checks, %0d errors", issued, checks, total);
		if (total == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== include/decode_cfg.svh ====
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// sizes fixed by the MIPS instruction format

// datapath and register word
`define DECODE_DATA_W      32

// general purpose register file
`define DECODE_REG_COUNT   32
`define DECODE_REG_ADDR_W  5

`endif

// ==== logic/control_decoder.sv ====
`timescale 1ns/1ps
`include "decode_cfg.svh"

module control_decoder (
	input  decode_pkg::instr_u instr,
	output decode_pkg::ctrl_t  ctrl
);
	import decode_pkg::*;

	always_comb
	begin
		ctrl = '0;	// unknown opcode leaves everything cleared
		case (instr.j.opcode)
			OP_RTYPE:
			begin
				case (instr.r.funct)
					FN_ADD: ctrl.ex.alu_op = ALU_ADD;
					FN_SUB: ctrl.ex.alu_op = ALU_SUB;
					FN_AND: ctrl.ex.alu_op = ALU_AND;
					FN_OR:  ctrl.ex.alu_op = ALU_OR;
					FN_SLT: ctrl.ex.alu_op = ALU_SLT;
					FN_SLL: ctrl.ex.alu_op = ALU_SLL;
					FN_SRL: ctrl.ex.alu_op = ALU_SRL;
					FN_JR:  ctrl.ex.jump_reg = 1'b1;	// no write back
					default: ctrl.ex.alu_op = ALU_NOP;
				endcase
				// every computing function writes rd
				if (ctrl.ex.alu_op != ALU_NOP)
				begin
					ctrl.ex.reg_dst_rd = 1'b1;
					ctrl.wb.reg_write  = 1'b1;
				end
			end
			OP_LW:
			begin
				ctrl.ex.alu_op      = ALU_ADD;	// base + offset
				ctrl.ex.alu_src_imm = 1'b1;
				ctrl.mem.mem_read   = 1'b1;
				ctrl.wb.reg_write   = 1'b1;
				ctrl.wb.mem_to_reg  = 1'b1;
			end
			OP_SW:
			begin
				ctrl.ex.alu_op      = ALU_ADD;
				ctrl.ex.alu_src_imm = 1'b1;
				ctrl.mem.mem_write  = 1'b1;
			end
			OP_BEQ:
			begin
				ctrl.ex.alu_op    = ALU_SUB;	// compare by subtraction
				ctrl.ex.branch_eq = 1'b1;
			end
			OP_BNE:
			begin
				ctrl.ex.alu_op    = ALU_SUB;
				ctrl.ex.branch_ne = 1'b1;
			end
			OP_ADDI, OP_ANDI, OP_ORI, OP_LUI:
			begin
				ctrl.ex.alu_src_imm = 1'b1;
				ctrl.wb.reg_write   = 1'b1;
				case (instr.j.opcode)
					OP_ADDI: ctrl.ex.alu_op = ALU_ADD;
					OP_ANDI: ctrl.ex.alu_op = ALU_AND;
					OP_ORI:  ctrl.ex.alu_op = ALU_OR;
					default: ctrl.ex.alu_op = ALU_LUI;
				endcase
			end
			OP_J:
				ctrl.ex.jump = 1'b1;
			OP_JAL:
			begin
				ctrl.ex.jump      = 1'b1;
				ctrl.ex.link      = 1'b1;	// return address to $ra
				ctrl.wb.reg_write = 1'b1;
			end
			default:
				ctrl = '0;
		endcase
	end

endmodule

// ==== logic/decode_pkg.sv ====
`include "decode_cfg.svh"

package decode_pkg;

	//////////////////////////////////////////////////
	// opcodes (instr[31:26])
	//////////////////////////////////////////////////
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_J     = 6'h02;
	localparam logic [5:0] OP_JAL   = 6'h03;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_BNE   = 6'h05;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_ANDI  = 6'h0c;
	localparam logic [5:0] OP_ORI   = 6'h0d;
	localparam logic [5:0] OP_LUI   = 6'h0f;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;

	// R-type function field (instr[5:0])
	localparam logic [5:0] FN_SLL = 6'h00;
	localparam logic [5:0] FN_SRL = 6'h02;
	localparam logic [5:0] FN_JR  = 6'h08;
	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR  = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	// zero is nop, so a cleared control bundle is a bubble
	typedef enum logic [3:0] {
		ALU_NOP = 4'd0,
		ALU_ADD = 4'd1,
		ALU_SUB = 4'd2,
		ALU_AND = 4'd3,
		ALU_OR  = 4'd4,
		ALU_SLT = 4'd5,
		ALU_SLL = 4'd6,
		ALU_SRL = 4'd7,
		ALU_LUI = 4'd8
	} alu_op_e;

	//////////////////////////////////////////////////
	// instruction word, three views of the same 32 bits
	//////////////////////////////////////////////////
	typedef struct packed {
		logic [5:0]                    opcode;
		logic [`DECODE_REG_ADDR_W-1:0] rs;
		logic [`DECODE_REG_ADDR_W-1:0] rt;
		logic [`DECODE_REG_ADDR_W-1:0] rd;
		logic [4:0]                    shamt;
		logic [5:0]                    funct;
	} r_fields_t;

	typedef struct packed {
		logic [5:0]                    opcode;
		logic [`DECODE_REG_ADDR_W-1:0] rs;
		logic [`DECODE_REG_ADDR_W-1:0] rt;
		logic [15:0]                   imm;
	} i_fields_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] index;	// word index inside the 256 MB region
	} j_fields_t;

	typedef union packed {
		r_fields_t r;
		i_fields_t i;
		j_fields_t j;
	} instr_u;

	//////////////////////////////////////////////////
	// control groups, one per downstream stage
	//////////////////////////////////////////////////
	typedef struct packed {
		alu_op_e alu_op;
		logic    alu_src_imm;	// operand b from sign_ext
		logic    reg_dst_rd;	// dest is rd, else rt
		logic    branch_eq;
		logic    branch_ne;
		logic    link;	// jal writes return address
		logic    jump;
		logic    jump_reg;
	} ex_ctrl_t;

	typedef struct packed {
		logic mem_read;
		logic mem_write;
	} mem_ctrl_t;

	typedef struct packed {
		logic reg_write;
		logic mem_to_reg;
	} wb_ctrl_t;

	typedef struct packed {
		ex_ctrl_t  ex;
		mem_ctrl_t mem;
		wb_ctrl_t  wb;
	} ctrl_t;

	// ID/EX register contents
	typedef struct packed {
		logic [`DECODE_DATA_W-1:0]     pc_next;
		logic [`DECODE_DATA_W-1:0]     reg1;
		logic [`DECODE_DATA_W-1:0]     reg2;
		logic [`DECODE_DATA_W-1:0]     sign_ext;
		logic [`DECODE_REG_ADDR_W-1:0] rs;
		logic [`DECODE_REG_ADDR_W-1:0] rt;
		logic [`DECODE_REG_ADDR_W-1:0] rd;
		logic [4:0]                    shamt;
		ctrl_t                         ctrl;
	} id_ex_t;

	// write port coming back from write-back
	typedef struct packed {
		logic                          we;
		logic [`DECODE_REG_ADDR_W-1:0] addr;
		logic [`DECODE_DATA_W-1:0]     data;
	} wb_write_t;

endpackage

// ==== logic/decode_top.sv ====
`timescale 1ns/1ps
`include "decode_cfg.svh"

module decode_top (
	input  logic                      clk,
	input  logic                      reset,
	input  logic [`DECODE_DATA_W-1:0] pc_next,	// PC+4 from fetch
	input  decode_pkg::instr_u        instr,
	input  decode_pkg::wb_write_t     wb,
	input  logic                      flush,
	output decode_pkg::id_ex_t        id_ex,
	output logic                      stall,
	output logic                      jump_taken,
	output logic [`DECODE_DATA_W-1:0] jump_target
);
	import decode_pkg::*;

	ctrl_t                     ctrl;
	logic [`DECODE_DATA_W-1:0] read1;
	logic [`DECODE_DATA_W-1:0] read2;
	logic [`DECODE_DATA_W-1:0] jump_addr;

	//////////////////////////////////////////////////
	// decode and register read, side by side
	//////////////////////////////////////////////////
	control_decoder u_control (
		.instr (instr),
		.ctrl  (ctrl)
	);

	register_file u_regs (
		.clk     (clk),
		.reset   (reset),
		.wb      (wb),
		.rs_addr (instr.r.rs),
		.rt_addr (instr.r.rt),
		.read1   (read1),
		.read2   (read2)
	);

	id_ex_stage u_stage (
		.clk     (clk),
		.reset   (reset),
		.instr   (instr),
		.ctrl    (ctrl),
		.read1   (read1),
		.read2   (read2),
		.pc_next (pc_next),
		.flush   (flush),
		.id_ex   (id_ex),
		.stall   (stall)
	);

	//////////////////////////////////////////////////
	// jump resolution in ID
	//////////////////////////////////////////////////
	// jr takes rs, J-type keeps the upper PC bits
	always_comb
	begin
		if (ctrl.ex.jump_reg)
			jump_addr = read1;
		else
			jump_addr = {pc_next[`DECODE_DATA_W-1 -: 4], instr.j.index, 2'b00};
	end

	assign jump_taken  = !flush && (ctrl.ex.jump || ctrl.ex.jump_reg);
	assign jump_target = flush ? '0 : jump_addr;	// quiet while squashed

endmodule

// ==== logic/id_ex_stage.sv ====
`timescale 1ns/1ps
`include "decode_cfg.svh"

module id_ex_stage (
	input  logic                      clk,
	input  logic                      reset,
	input  decode_pkg::instr_u        instr,
	input  decode_pkg::ctrl_t         ctrl,
	input  logic [`DECODE_DATA_W-1:0] read1,
	input  logic [`DECODE_DATA_W-1:0] read2,
	input  logic [`DECODE_DATA_W-1:0] pc_next,
	input  logic                      flush,
	output decode_pkg::id_ex_t        id_ex,
	output logic                      stall
);
	import decode_pkg::*;

	logic   load_use;
	logic   rs_match;
	logic   rt_match;
	id_ex_t id_ex_next;

	//////////////////////////////////////////////////
	// load-use hazard
	//////////////////////////////////////////////////
	// the lw now in EX delivers its data too late for the
	// instruction in ID, so hold fetch one cycle
	assign rs_match = (id_ex.rt == instr.r.rs);
	assign rt_match = (id_ex.rt == instr.r.rt);

	assign load_use = id_ex.ctrl.mem.mem_read
		&& (id_ex.rt != '0)	// $zero never carries a dependency
		&& (rs_match || rt_match);

	assign stall = load_use && !flush;

	//////////////////////////////////////////////////
	// next register contents
	//////////////////////////////////////////////////
	always_comb
	begin
		id_ex_next.pc_next  = pc_next;
		id_ex_next.reg1     = read1;
		id_ex_next.reg2     = read2;
		// 16 bit immediate to full width, signed
		id_ex_next.sign_ext = {{(`DECODE_DATA_W-16){instr.i.imm[15]}}, instr.i.imm};
		id_ex_next.rs       = instr.r.rs;
		id_ex_next.rt       = instr.r.rt;
		id_ex_next.rd       = instr.r.rd;
		id_ex_next.shamt    = instr.r.shamt;

		if (load_use)
			id_ex_next.ctrl = '0;	// bubble, data fields still load
		else
			id_ex_next.ctrl = ctrl;
	end

	//////////////////////////////////////////////////
	// ID/EX register
	//////////////////////////////////////////////////
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			id_ex <= '0;
		end
		else if (flush)
		begin
			id_ex <= '0;	// squash the whole slot
		end
		else
		begin
			id_ex <= id_ex_next;
		end
	end

endmodule

// ==== logic/register_file.sv ====
`timescale 1ns/1ps
`include "decode_cfg.svh"

module register_file (
	input  logic                          clk,
	input  logic                          reset,
	input  decode_pkg::wb_write_t         wb,
	input  logic [`DECODE_REG_ADDR_W-1:0] rs_addr,
	input  logic [`DECODE_REG_ADDR_W-1:0] rt_addr,
	output logic [`DECODE_DATA_W-1:0]     read1,
	output logic [`DECODE_DATA_W-1:0]     read2
);

	logic [`DECODE_DATA_W-1:0] regs [`DECODE_REG_COUNT];

	// one read port, with write-through and $zero
	function automatic logic [`DECODE_DATA_W-1:0] read_port(
		input logic [`DECODE_REG_ADDR_W-1:0] addr
	);
		if (addr == '0)
			return '0;
		else if (wb.we && (wb.addr == addr))
			return wb.data;	// bypass the write landing this cycle
		else
			return regs[addr];
	endfunction

	//////////////////////////////////////////////////
	// write port
	//////////////////////////////////////////////////
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < `DECODE_REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (wb.we && (wb.addr != '0))
		begin
			regs[wb.addr] <= wb.data;	// writes to $zero dropped
		end
	end

	always_comb
	begin
		read1 = read_port(rs_addr);
		read2 = read_port(rt_addr);
	end

endmodule

// ==== mips_decode.f ====
+incdir+include
logic/decode_pkg.sv
logic/control_decoder.sv
logic/register_file.sv
logic/id_ex_stage.sv
logic/decode_top.sv
bench/decode_tb.sv
